// File: common/scoreboard_settings.svh
`ifndef SCOREBOARD_SETTINGS_SVH
`define SCOREBOARD_SETTINGS_SVH

`define SCORE_W    3
`define SEG_W      7   // Segments a to g
`define DIGITS     8
`define LCD_DATA_W 8
`define IVL_W      9
`define COL_W      5

// Phase end counts
`define T_POWERUP  9'd70
`define T_SETUP    9'd30
`define T_LINE     9'd20
`define T_HOME     9'd400
`define T_CLEAR    9'd200

`define CMD_FUNC   8'h3C   // 8-bit bus, 2 lines, 5x10 font
`define CMD_ENTRY  8'h06
`define CMD_DISP   8'h0C   // Display on, no cursor
`define CMD_LINE1  8'h80
`define CMD_LINE2  8'hC0
`define CMD_HOME   8'h02
`define CMD_CLEAR  8'h01

`define CHAR_SPACE 8'h20
`define CHAR_HEART 8'h9D

`define MSG_LEN    9   // Columns carrying message text

`endif

// File: common/scoreboard_pkg.sv
package scoreboard_pkg;

    typedef enum logic [1:0] {
        COLOR_HOLD  = 2'd0,
        COLOR_RED   = 2'd1,
        COLOR_GREEN = 2'd2,
        COLOR_BLUE  = 2'd3
    } color_t;

    // Code 3 reads as no winner
    typedef enum logic [1:0] {
        WIN_NONE = 2'd0,
        WIN_P1   = 2'd1,
        WIN_P2   = 2'd2
    } winner_t;

    typedef enum logic [2:0] {
        PH_POWERUP = 3'd0,
        PH_FUNC    = 3'd1,
        PH_ENTRY   = 3'd2,
        PH_DISP    = 3'd3,
        PH_LINE1   = 3'd4,
        PH_LINE2   = 3'd5,
        PH_HOME    = 3'd6,
        PH_CLEAR   = 3'd7
    } lcd_phase_t;

    typedef enum logic {
        LINE_TOP    = 1'b0,
        LINE_BOTTOM = 1'b1
    } lcd_line_t;

endpackage

// File: rtl/player_led.sv
module player_led
    import scoreboard_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  color_t color_1,
    input  color_t color_2,
    output logic   led_1_r,
    output logic   led_1_g,
    output logic   led_1_b,
    output logic   led_2_r,
    output logic   led_2_g,
    output logic   led_2_b
);
    logic [2:0] rgb_1;
    logic [2:0] rgb_2;

    function automatic logic [2:0] rgb_of(color_t color, logic [2:0] prev);
        case (color)
            COLOR_RED:   rgb_of = 3'b100;
            COLOR_GREEN: rgb_of = 3'b010;
            COLOR_BLUE:  rgb_of = 3'b001;
            default:     rgb_of = prev;   // Hold
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            rgb_1 <= '0;
            rgb_2 <= '0;
        end else begin
            rgb_1 <= rgb_of(color_1, rgb_1);
            rgb_2 <= rgb_of(color_2, rgb_2);
        end
    end

    assign {led_1_r, led_1_g, led_1_b} = rgb_1;
    assign {led_2_r, led_2_g, led_2_b} = rgb_2;

endmodule

// File: rtl/seg_scan.sv
`include "scoreboard_settings.svh"

module seg_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic [`SCORE_W-1:0] score_1,
    input  logic [`SCORE_W-1:0] score_2,
    output logic [`SEG_W-1:0]   seg,
    output logic [`DIGITS-1:0]  digit_pos
);
    logic [`SEG_W-1:0]          digit_1;
    logic [`SEG_W-1:0]          digit_2;
    logic [$clog2(`DIGITS)-1:0] scan_cnt;

    function automatic logic [`SEG_W-1:0] seg_of(logic [`SCORE_W-1:0] score);
        case (score)
            3'd1:    seg_of = 7'b0110000;
            3'd2:    seg_of = 7'b1101101;
            3'd3:    seg_of = 7'b1111001;
            3'd4:    seg_of = 7'b0110011;
            3'd5:    seg_of = 7'b1011011;
            default: seg_of = 7'b0000000;   // Blank
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            digit_1   <= '0;
            digit_2   <= '0;
            scan_cnt  <= '0;
            seg       <= '0;
            digit_pos <= '0;
        end else begin
            digit_1   <= seg_of(score_1);
            digit_2   <= seg_of(score_2);
            scan_cnt  <= scan_cnt + 1'b1;
            digit_pos <= {{(`DIGITS-1){1'b0}}, 1'b1} << scan_cnt;
            if (scan_cnt == '0) begin
                seg <= digit_1;   // Rightmost digit
            end else if (scan_cnt == '1) begin
                seg <= digit_2;   // Leftmost digit
            end else begin
                seg <= '0;
            end
        end
    end

endmodule

// File: lcd/lcd_message_rom.sv
`include "scoreboard_settings.svh"

module lcd_message_rom
    import scoreboard_pkg::*;
(
    input  winner_t                winner,
    input  lcd_line_t              line,
    input  logic [`COL_W-1:0]      column,
    output logic [`LCD_DATA_W-1:0] char
);
    logic has_winner;

    assign has_winner = (winner == WIN_P1) || (winner == WIN_P2);

    always_comb begin
        char = `CHAR_SPACE;
        if (has_winner) begin
            if (line == LINE_TOP) begin
                case (column)
                    5'd2:    char = 8'h50;   // P
                    5'd3:    char = (winner == WIN_P1) ? 8'h31 : 8'h32;
                    5'd5:    char = 8'h57;   // W
                    5'd6:    char = 8'h69;   // i
                    5'd7:    char = 8'h6E;   // n
                    default: char = `CHAR_SPACE;
                endcase
            end else begin
                // Two groups of three hearts
                case (column)
                    5'd2, 5'd3, 5'd4: char = `CHAR_HEART;
                    5'd6, 5'd7, 5'd8: char = `CHAR_HEART;
                    default:          char = `CHAR_SPACE;
                endcase
            end
        end
    end

endmodule

// File: lcd/lcd_sequencer.sv
`include "scoreboard_settings.svh"

module lcd_sequencer
    import scoreboard_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`LCD_DATA_W-1:0] char,
    output lcd_line_t              line,
    output logic [`COL_W-1:0]      column,
    output logic                   lcd_e,
    output logic                   lcd_rs,
    output logic                   lcd_rw,
    output logic [`LCD_DATA_W-1:0] lcd_data
);
    lcd_phase_t             phase;
    lcd_phase_t             phase_next;
    logic [`IVL_W-1:0]      ivl;
    logic [`IVL_W-1:0]      ivl_end;
    logic [`LCD_DATA_W-1:0] cmd;
    logic                   is_char;

    always_comb begin
        phase_next = lcd_phase_t'(phase + 3'd1);
        case (phase)
            PH_POWERUP: begin
                ivl_end = `T_POWERUP;
                cmd     = '0;
            end
            PH_FUNC: begin
                ivl_end = `T_SETUP;
                cmd     = `CMD_FUNC;
            end
            PH_ENTRY: begin
                ivl_end = `T_SETUP;
                cmd     = `CMD_ENTRY;
            end
            PH_DISP: begin
                ivl_end = `T_SETUP;
                cmd     = `CMD_DISP;
            end
            PH_LINE1: begin
                ivl_end = `T_LINE;
                cmd     = `CMD_LINE1;
            end
            PH_LINE2: begin
                ivl_end = `T_LINE;
                cmd     = `CMD_LINE2;
            end
            PH_HOME: begin
                ivl_end = `T_HOME;
                cmd     = `CMD_HOME;
            end
            default: begin
                ivl_end    = `T_CLEAR;
                cmd        = `CMD_CLEAR;
                phase_next = PH_LINE1;   // Refresh loop
            end
        endcase
    end

    // Interval 0 of a line phase is the address command
    assign is_char = (phase == PH_LINE1 || phase == PH_LINE2) && (ivl != '0);
    assign line    = (phase == PH_LINE2) ? LINE_BOTTOM : LINE_TOP;
    assign column  = ivl[`COL_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase    <= PH_POWERUP;
            ivl      <= '0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
        end else begin
            if (ivl == ivl_end) begin
                ivl   <= '0;
                phase <= phase_next;
            end else begin
                ivl <= ivl + 1'b1;
            end
            if (phase == PH_POWERUP) begin   // Bus idle while the panel powers up
                lcd_e    <= 1'b0;
                lcd_rs   <= 1'b1;
                lcd_rw   <= 1'b1;
                lcd_data <= '0;
            end else begin
                lcd_e    <= 1'b1;
                lcd_rs   <= is_char;
                lcd_rw   <= 1'b0;
                lcd_data <= is_char ? char : cmd;
            end
        end
    end

endmodule

// File: rtl/scoreboard_top.sv
`include "scoreboard_settings.svh"

module scoreboard_top
    import scoreboard_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  color_t                 color_1,
    input  color_t                 color_2,
    input  logic [`SCORE_W-1:0]    score_1,
    input  logic [`SCORE_W-1:0]    score_2,
    input  winner_t                winner,
    output logic                   led_1_r,
    output logic                   led_1_g,
    output logic                   led_1_b,
    output logic                   led_2_r,
    output logic                   led_2_g,
    output logic                   led_2_b,
    output logic [`SEG_W-1:0]      seg,
    output logic [`DIGITS-1:0]     digit_pos,
    output logic                   lcd_e,
    output logic                   lcd_rs,
    output logic                   lcd_rw,
    output logic [`LCD_DATA_W-1:0] lcd_data
);
    lcd_line_t              line;
    logic [`COL_W-1:0]      column;
    logic [`LCD_DATA_W-1:0] char;

    player_led u_led (
        .clk     (clk),
        .rst     (rst),
        .color_1 (color_1),
        .color_2 (color_2),
        .led_1_r (led_1_r),
        .led_1_g (led_1_g),
        .led_1_b (led_1_b),
        .led_2_r (led_2_r),
        .led_2_g (led_2_g),
        .led_2_b (led_2_b)
    );

    seg_scan u_seg (
        .clk       (clk),
        .rst       (rst),
        .score_1   (score_1),
        .score_2   (score_2),
        .seg       (seg),
        .digit_pos (digit_pos)
    );

    lcd_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .char     (char),
        .line     (line),
        .column   (column),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

    // Message text picked by the current winner
    lcd_message_rom u_rom (
        .winner (winner),
        .line   (line),
        .column (column),
        .char   (char)
    );

endmodule

// File: verification/scoreboard_checker.sv
`include "scoreboard_settings.svh"

module scoreboard_checker
    import scoreboard_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input color_t                 color_1,
    input color_t                 color_2,
    input logic [`SCORE_W-1:0]    score_1,
    input logic [`SCORE_W-1:0]    score_2,
    input winner_t                winner,
    input logic                   led_1_r,
    input logic                   led_1_g,
    input logic                   led_1_b,
    input logic                   led_2_r,
    input logic                   led_2_g,
    input logic                   led_2_b,
    input logic [`SEG_W-1:0]      seg,
    input logic [`DIGITS-1:0]     digit_pos,
    input logic                   lcd_e,
    input logic                   lcd_rs,
    input logic                   lcd_rw,
    input logic [`LCD_DATA_W-1:0] lcd_data
);
    localparam logic [63:0] INIT_ORDER = {`CMD_FUNC, `CMD_ENTRY, `CMD_DISP, `CMD_LINE1,
                                          `CMD_LINE2, `CMD_HOME, `CMD_CLEAR, `CMD_LINE1};

    logic [4:0]              active = 5'b11111;
    int                      checks [5];
    int                      errs [5];
    int                      total_errors;
    logic                    started = 1'b0;
    logic                    rst_at_pos = 1'b0;   // Reset as seen by the last edge
    logic [2:0]              rgb_1_exp = '0;
    logic [2:0]              rgb_2_exp = '0;
    logic [`DIGITS-1:0]      pos_exp = '0;
    logic [`SEG_W-1:0]       seg_exp;
    logic [2*`SCORE_W-1:0]   score_d1 = '0;
    logic [2*`SCORE_W-1:0]   score_d2 = '0;
    logic [`LCD_DATA_W-1:0]  cmd_seen [$];
    logic [`LCD_DATA_W-1:0]  run_byte = '0;
    int                      run_len = 0;
    int                      col = 0;
    int                      lines_done = 0;
    logic                    line_open = 1'b0;
    logic                    on_bottom = 1'b0;

    function automatic string test_name(int id);
        case (id)
            0:       return "reset_state";
            1:       return "led_color";
            2:       return "seg_scan";
            3:       return "lcd_init";
            default: return "lcd_message";
        endcase
    endfunction

    function automatic logic [`SEG_W-1:0] seg_ref(logic [`SCORE_W-1:0] score);
        case (score)
            1:       return 7'b0110000;
            2:       return 7'b1101101;
            3:       return 7'b1111001;
            4:       return 7'b0110011;
            5:       return 7'b1011011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic logic [2:0] led_ref(color_t code, logic [2:0] prev);
        case (code)
            COLOR_RED:   return 3'b100;
            COLOR_GREEN: return 3'b010;
            COLOR_BLUE:  return 3'b001;
            default:     return prev;
        endcase
    endfunction

    function automatic logic [7:0] msg_ref(winner_t w, logic bottom, int pos);
        string top;
        if ((w != WIN_P1 && w != WIN_P2) || pos < 1 || pos > `MSG_LEN)
            return `CHAR_SPACE;
        if (bottom)
            return (pos == 1 || pos == 5 || pos == 9) ? `CHAR_SPACE : `CHAR_HEART;
        top = (w == WIN_P1) ? " P1 Win  " : " P2 Win  ";
        return top[pos-1];
    endfunction

    task automatic compare(input int id, input logic [31:0] exp, input logic [31:0] act);
        checks[id]++;
        if (act !== exp) begin
            errs[id]++;
            $display("ERR %s expected %0h actual %0h", test_name(id), exp, act);
        end
    endtask

    task automatic report_failure(input int id, input string text);
        errs[id]++;
        $display("%s: %s", test_name(id), text);
    endtask

    task automatic watch_command;
        compare(3, 0, lcd_rw);
        if (!lcd_rs && (run_len == 0 || lcd_data != run_byte)) begin
            if (run_byte == `CMD_FUNC || run_byte == `CMD_ENTRY || run_byte == `CMD_DISP)
                compare(3, `T_SETUP + 1, run_len);
            cmd_seen.push_back(lcd_data);
            run_byte = lcd_data;
            run_len  = 1;
        end else if (!lcd_rs) begin
            run_len++;
        end
    endtask

    task automatic watch_message;
        if (!lcd_rs) begin
            if (line_open && col == `T_LINE)
                lines_done++;
            else if (line_open)
                report_failure(4, $sformatf("a message line ended after %0d characters", col));
            line_open = (lcd_data == `CMD_LINE1) || (lcd_data == `CMD_LINE2);
            on_bottom = (lcd_data == `CMD_LINE2);
            col       = 0;
        end else begin
            col++;
            if (!line_open || col > `T_LINE)
                report_failure(4, "a character was written outside a message line");
            else
                compare(4, msg_ref(winner, on_bottom, col), lcd_data);
        end
    endtask

    task automatic finish_test(input int id);
        int i;
        if (id == 3 && cmd_seen.size() < 8)
            report_failure(3, "fewer than eight LCD commands were seen");
        else if (id == 3)
            for (i = 0; i < 8; i++)
                compare(3, INIT_ORDER[63-8*i -: 8], cmd_seen[i]);
        if (id == 4 && lines_done < 6)
            report_failure(4, $sformatf("only %0d of six message lines were seen", lines_done));
        if (checks[id] == 0)
            report_failure(id, "no checks were made");
        active[id] = 1'b0;
        $display("%-12s %s  %0d checks, %0d errors", test_name(id),
                 (errs[id] == 0) ? "ok  " : "FAIL", checks[id], errs[id]);
    endtask

    task automatic summary;
        int i;
        int failed;
        failed       = 0;
        total_errors = 0;
        for (i = 0; i < 5; i++) begin
            total_errors += errs[i];
            if (errs[i] != 0)
                failed++;
        end
        $display("Summary: 5 tests, %0d failed, %0d errors", failed, total_errors);
    endtask

    always @(posedge clk) begin
        rst_at_pos <= rst;
        if (!rst)
            started <= 1'b1;
    end

    always @(negedge clk) begin
        if (started && active[0] && !rst_at_pos) begin
            compare(0, {21'd0, 3'b011, 8'h00},
                    {led_1_r, led_1_g, led_1_b, led_2_r, led_2_g, led_2_b,
                     seg, digit_pos, lcd_e, lcd_rs, lcd_rw, lcd_data});
        end
        if (started && rst_at_pos) begin
            if (active[1])
                compare(1, {rgb_1_exp, rgb_2_exp},
                        {led_1_r, led_1_g, led_1_b, led_2_r, led_2_g, led_2_b});
            if (active[2]) begin
                seg_exp = pos_exp[0] ? seg_ref(score_d2[`SCORE_W-1:0]) :
                          pos_exp[`DIGITS-1] ? seg_ref(score_d2[2*`SCORE_W-1:`SCORE_W]) :
                          {`SEG_W{1'b0}};
                compare(2, pos_exp, digit_pos);
                compare(2, seg_exp, seg);
            end
            if (lcd_e && active[3])
                watch_command();
            if (lcd_e && active[4])
                watch_message();
        end
        // State expected after the coming edge
        rgb_1_exp = rst ? led_ref(color_1, rgb_1_exp) : 3'b000;
        rgb_2_exp = rst ? led_ref(color_2, rgb_2_exp) : 3'b000;
        if (!rst)
            pos_exp = '0;
        else if (pos_exp == '0)
            pos_exp = {{(`DIGITS-1){1'b0}}, 1'b1};
        else
            pos_exp = {pos_exp[`DIGITS-2:0], pos_exp[`DIGITS-1]};
        score_d2 = score_d1;   // Two cycles from score to seg
        score_d1 = {score_2, score_1};
    end

endmodule

// File: verification/tb_scoreboard.sv
`include "scoreboard_settings.svh"

module tb_scoreboard
    import scoreboard_pkg::*;
();
    localparam int CLK_PERIOD      = 40;
    localparam int WATCHDOG_CYCLES = 164 + 3 * 644 + 200;   // Init, three LCD loops, margin

    logic                   clk;
    logic                   rst;
    color_t                 color_1;
    color_t                 color_2;
    logic [`SCORE_W-1:0]    score_1;
    logic [`SCORE_W-1:0]    score_2;
    winner_t                winner;
    logic                   led_1_r;
    logic                   led_1_g;
    logic                   led_1_b;
    logic                   led_2_r;
    logic                   led_2_g;
    logic                   led_2_b;
    logic [`SEG_W-1:0]      seg;
    logic [`DIGITS-1:0]     digit_pos;
    logic                   lcd_e;
    logic                   lcd_rs;
    logic                   lcd_rw;
    logic [`LCD_DATA_W-1:0] lcd_data;
    integer                 seed;

    scoreboard_top uut (.*);

    scoreboard_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the LCD loops did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // Inputs change a little after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    function automatic logic at_home();
        return lcd_e && !lcd_rs && (lcd_data == `CMD_HOME);
    endfunction

    // Returns early in the next PH_HOME phase
    task automatic wait_for_home;
        @(negedge clk);
        while (at_home()) @(negedge clk);
        while (!at_home()) @(negedge clk);
        step(1);
    endtask

    task automatic drive_colors(input int n);
        logic [31:0] r;
        repeat (n) begin
            r       = $random(seed);
            color_1 = color_t'(r[1:0]);
            color_2 = color_t'(r[3:2]);
            step(3);
        end
        color_1 = COLOR_HOLD;
        color_2 = COLOR_HOLD;
    endtask

    task automatic drive_scores(input int n);
        logic [31:0] r;
        repeat (n) begin
            r       = $random(seed);
            score_1 = r[2:0];
            score_2 = r[5:3];
            step(16);
        end
    endtask

    initial begin
        seed    = 62137;
        rst     = 1'b0;
        color_1 = COLOR_HOLD;
        color_2 = COLOR_HOLD;
        score_1 = '0;
        score_2 = '0;
        winner  = WIN_P1;
        step(10);
        rst = 1'b1;
        step(1);
        chk.finish_test(0);
        fork
            begin
                drive_colors(30);
                step(2);
                chk.finish_test(1);
                drive_scores(12);
                step(2);
                chk.finish_test(2);
            end
            begin
                wait_for_home();
                winner = WIN_P2;
                wait_for_home();
                winner = WIN_NONE;
                wait_for_home();
            end
        join
        chk.finish_test(3);
        chk.finish_test(4);
        chk.summary();
        if (chk.total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/scoreboard_pkg.sv
rtl/player_led.sv
rtl/seg_scan.sv
lcd/lcd_message_rom.sv
lcd/lcd_sequencer.sv
rtl/scoreboard_top.sv
verification/scoreboard_checker.sv
verification/tb_scoreboard.sv

// File: Bender.yml
package:
  name: scoreboard

sources:
  - include_dirs:
      - common
    files:
      - common/scoreboard_pkg.sv
      - rtl/player_led.sv
      - rtl/seg_scan.sv
      - lcd/lcd_message_rom.sv
      - lcd/lcd_sequencer.sv
      - rtl/scoreboard_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/scoreboard_checker.sv
      - verification/tb_scoreboard.sv
